//--- Bender.yml
package:
  name: xif_copro

sources:
  # Coprocessor RTL, package first
  - files:
      - design/xif_pkg.sv
      - design/xif_fifo.sv
      - design/xif_issue_decode.sv
      - design/xif_commit_hold.sv
      - design/xif_exec_unit.sv
      - design/xif_copro_top.sv

  # Testbench, checker and bound assertions
  - target: test
    files:
      - dv/xif_protocol_sva.sv
      - dv/xif_scoreboard.sv
      - dv/tb_xif_copro.sv

//--- build.f
design/xif_pkg.sv
design/xif_fifo.sv
design/xif_issue_decode.sv
design/xif_commit_hold.sv
design/xif_exec_unit.sv
design/xif_copro_top.sv
dv/xif_protocol_sva.sv
dv/xif_scoreboard.sv
dv/tb_xif_copro.sv

//--- design/xif_commit_hold.sv
/*
 * Commit stage. Parks accepted instructions by id until the core commits or
 * kills them; committed ones leave in commit order towards execution.
 */

`timescale 1ns/10ps
`default_nettype none

module xif_commit_hold (
   input  wire logic                        clk,
   input  wire logic                        reset_n,
   input  wire logic                        uop_valid_i,
   input  wire xif_pkg::uop_t               uop_i,
   input  wire logic                        commit_valid_i,
   input  wire xif_pkg::commit_t            commit_i,
   output logic [xif_pkg::NUM_IDS-1:0]      id_busy_o,
   output logic                             kill_o,
   output logic                             out_valid_o,
   output xif_pkg::uop_t                    out_o,
   input  wire logic                        out_ready_i
);

   import xif_pkg::*;

   logic [NUM_IDS-1:0]    occupied_q;
   logic [NUM_IDS-1:0]    committed_q;
   uop_t                  uop_q [NUM_IDS];

   logic [X_ID_WIDTH-1:0] rq_id_q [NUM_IDS];
   logic [X_ID_WIDTH-1:0] rq_head_q;
   logic [X_ID_WIDTH-1:0] rq_tail_q;
   logic [X_ID_WIDTH:0]   rq_count_q;
   logic [X_ID_WIDTH-1:0] head_id;

   logic                  cmt_hit;
   logic                  cmt_push;
   logic                  rq_pop;

   // --------------------
   // Commit match
   // --------------------
   // An entry written this cycle counts too, so a same-cycle commit is kept.
   // Commits for rejected ids find no entry and are ignored
   assign cmt_hit = commit_valid_i &&
                    ((occupied_q[commit_i.id] && !committed_q[commit_i.id]) ||
                     (uop_valid_i && (uop_i.id == commit_i.id)));

   assign kill_o   = cmt_hit && commit_i.kill;
   assign cmt_push = cmt_hit && !commit_i.kill;

   assign id_busy_o = occupied_q;

   // --------------------
   // Release queue output
   // --------------------
   assign head_id     = rq_id_q[rq_head_q];
   assign out_valid_o = (rq_count_q != '0);
   assign out_o       = uop_q[head_id];
   assign rq_pop      = out_valid_o && out_ready_i;

   // Entry flags
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         occupied_q  <= '0;
         committed_q <= '0;
      end else begin
         if (uop_valid_i) begin
            occupied_q[uop_i.id]  <= 1'b1;
            committed_q[uop_i.id] <= 1'b0;
         end
         if (cmt_hit) begin
            if (commit_i.kill) begin
               occupied_q[commit_i.id]  <= 1'b0;
               committed_q[commit_i.id] <= 1'b0;
            end else begin
               committed_q[commit_i.id] <= 1'b1;
            end
         end
         // Slot is free once the uop moves on
         if (rq_pop) begin
            occupied_q[head_id]  <= 1'b0;
            committed_q[head_id] <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (uop_valid_i) begin
         uop_q[uop_i.id] <= uop_i;
      end
      if (cmt_push) begin
         rq_id_q[rq_tail_q] <= commit_i.id;
      end
   end

   // Queue never overflows, at most NUM_IDS entries can be committed
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         rq_head_q  <= '0;
         rq_tail_q  <= '0;
         rq_count_q <= '0;
      end else begin
         if (cmt_push) begin
            rq_tail_q <= rq_tail_q + 1'b1;
         end
         if (rq_pop) begin
            rq_head_q <= rq_head_q + 1'b1;
         end
         case ({cmt_push, rq_pop})
            2'b10:   rq_count_q <= rq_count_q + 1'b1;
            2'b01:   rq_count_q <= rq_count_q - 1'b1;
            default: rq_count_q <= rq_count_q;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- design/xif_copro_top.sv
/*
 * Coprocessor top level. Chains issue decode, commit hold, pending FIFO,
 * execute stage and result FIFO behind the issue/commit/result channels.
 */

`timescale 1ns/10ps
`default_nettype none

module xif_copro_top (
   input  wire logic                 clk,
   input  wire logic                 reset_n,
   // Issue channel
   input  wire logic                 issue_valid_i,
   input  wire xif_pkg::issue_req_t  issue_req_i,
   output logic                      issue_ready_o,
   output xif_pkg::issue_resp_t      issue_resp_o,
   // Commit channel
   input  wire logic                 commit_valid_i,
   input  wire xif_pkg::commit_t     commit_i,
   // Result channel
   output logic                      result_valid_o,
   output xif_pkg::result_t          result_o,
   input  wire logic                 result_ready_i
);

   import xif_pkg::*;

   logic               dec_valid;
   uop_t               dec_uop;
   logic [NUM_IDS-1:0] id_busy;
   logic               kill;
   logic [1:0]         retire;

   logic               hold_valid;
   uop_t               hold_uop;
   logic               hold_ready;

   logic               pend_valid;
   uop_t               pend_uop;
   logic               pend_ready;

   logic               exe_valid;
   result_t            exe_result;
   logic               exe_ready;

   // Bit 0 result read, bit 1 kill
   assign retire = {kill, result_valid_o && result_ready_i};

   xif_issue_decode u_decode (
      .clk           (clk),
      .reset_n       (reset_n),
      .issue_valid_i (issue_valid_i),
      .issue_req_i   (issue_req_i),
      .issue_ready_o (issue_ready_o),
      .issue_resp_o  (issue_resp_o),
      .id_busy_i     (id_busy),
      .retire_i      (retire),
      .uop_valid_o   (dec_valid),
      .uop_o         (dec_uop)
   );

   xif_commit_hold u_hold (
      .clk            (clk),
      .reset_n        (reset_n),
      .uop_valid_i    (dec_valid),
      .uop_i          (dec_uop),
      .commit_valid_i (commit_valid_i),
      .commit_i       (commit_i),
      .id_busy_o      (id_busy),
      .kill_o         (kill),
      .out_valid_o    (hold_valid),
      .out_o          (hold_uop),
      .out_ready_i    (hold_ready)
   );

   xif_fifo #(.DEPTH(PEND_FIFO_DEPTH), .payload_t(uop_t)) u_pend_fifo (
      .clk         (clk),
      .reset_n     (reset_n),
      .in_valid_i  (hold_valid),
      .in_data_i   (hold_uop),
      .in_ready_o  (hold_ready),
      .out_valid_o (pend_valid),
      .out_data_o  (pend_uop),
      .out_ready_i (pend_ready)
   );

   xif_exec_unit u_exec (
      .clk          (clk),
      .reset_n      (reset_n),
      .in_valid_i   (pend_valid),
      .in_uop_i     (pend_uop),
      .in_ready_o   (pend_ready),
      .out_valid_o  (exe_valid),
      .out_result_o (exe_result),
      .out_ready_i  (exe_ready)
   );

   xif_fifo #(.DEPTH(RES_FIFO_DEPTH), .payload_t(result_t)) u_res_fifo (
      .clk         (clk),
      .reset_n     (reset_n),
      .in_valid_i  (exe_valid),
      .in_data_i   (exe_result),
      .in_ready_o  (exe_ready),
      .out_valid_o (result_valid_o),
      .out_data_o  (result_o),
      .out_ready_i (result_ready_i)
   );

endmodule

`default_nettype wire

//--- design/xif_exec_unit.sv
/*
 * Execute stage. One register stage computing add, xor, rotate-left or
 * checked add; the result is held while the downstream side stalls.
 */

`timescale 1ns/10ps
`default_nettype none

module xif_exec_unit (
   input  wire logic          clk,
   input  wire logic          reset_n,
   input  wire logic          in_valid_i,
   input  wire xif_pkg::uop_t in_uop_i,
   output logic               in_ready_o,
   output logic               out_valid_o,
   output xif_pkg::result_t   out_result_o,
   input  wire logic          out_ready_i
);

   import xif_pkg::*;

   logic [XLEN-1:0]   sum;
   logic [2*XLEN-1:0] rot_wide;
   logic              overflow;
   result_t           res_d;
   result_t           res_q;
   logic              valid_q;

   // --------------------
   // Datapath
   // --------------------
   assign sum = in_uop_i.rs0 + in_uop_i.rs1;

   // Signed overflow: same operand signs, different result sign
   assign overflow = (in_uop_i.rs0[XLEN-1] == in_uop_i.rs1[XLEN-1]) &&
                     (sum[XLEN-1] != in_uop_i.rs0[XLEN-1]);

   // Rotate via a doubled word; upper half holds the rotated value
   assign rot_wide = {in_uop_i.rs0, in_uop_i.rs0} << in_uop_i.rs1[4:0];

   always_comb begin
      res_d    = '0;
      res_d.id = in_uop_i.id;
      res_d.rd = in_uop_i.rd;
      res_d.we = 1'b1;
      case (in_uop_i.op)
         OP_ADD:  res_d.data = sum;
         OP_XOR:  res_d.data = in_uop_i.rs0 ^ in_uop_i.rs1;
         OP_ROTL: res_d.data = rot_wide[2*XLEN-1:XLEN];
         default: begin
            if (overflow) begin
               res_d.exc     = 1'b1;
               res_d.exccode = EXC_OVERFLOW;
               res_d.we      = 1'b0;
            end else begin
               res_d.data = sum;
            end
         end
      endcase
   end

   // --------------------
   // Output register
   // --------------------
   assign in_ready_o   = !valid_q || out_ready_i;
   assign out_valid_o  = valid_q;
   assign out_result_o = res_q;

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         valid_q <= 1'b0;
      end else if (in_ready_o) begin
         valid_q <= in_valid_i;
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid_i && in_ready_o) begin
         res_q <= res_d;
      end
   end

endmodule

`default_nettype wire

//--- design/xif_fifo.sv
/*
 * Synchronous FIFO with valid/ready on both sides and a generic payload.
 * The head appears on the output in the cycle after it is written.
 */

`timescale 1ns/10ps
`default_nettype none

module xif_fifo #(
   parameter int  DEPTH     = 2,
   parameter type payload_t = logic
) (
   input  wire logic     clk,
   input  wire logic     reset_n,
   input  wire logic     in_valid_i,
   input  wire payload_t in_data_i,
   output logic          in_ready_o,
   output logic          out_valid_o,
   output payload_t      out_data_o,
   input  wire logic     out_ready_i
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   payload_t         mem_q [DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;
   logic             do_wr;
   logic             do_rd;

   assign in_ready_o  = (count_q != CNT_W'(DEPTH));
   assign out_valid_o = (count_q != '0);
   assign out_data_o  = mem_q[rd_ptr_q];

   assign do_wr = in_valid_i && in_ready_o;
   assign do_rd = out_valid_o && out_ready_i;

   // Storage
   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem_q[wr_ptr_q] <= in_data_i;
      end
   end

   // --------------------
   // Pointers and count
   // --------------------
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (do_wr) begin
            // Wrap explicitly, depth need not be a power of two
            wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (do_rd) begin
            rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         end
         case ({do_wr, do_rd})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- design/xif_issue_decode.sv
/*
 * Issue stage. Decides acceptance in the same cycle as the offer, builds the
 * issue response and tracks how many instructions are in flight.
 */

`timescale 1ns/10ps
`default_nettype none

module xif_issue_decode (
   input  wire logic                        clk,
   input  wire logic                        reset_n,
   input  wire logic                        issue_valid_i,
   input  wire xif_pkg::issue_req_t         issue_req_i,
   output logic                             issue_ready_o,
   output xif_pkg::issue_resp_t             issue_resp_o,
   input  wire logic [xif_pkg::NUM_IDS-1:0] id_busy_i,
   input  wire logic [1:0]                  retire_i,
   output logic                             uop_valid_o,
   output xif_pkg::uop_t                    uop_o
);

   import xif_pkg::*;

   logic [6:0]                opcode;
   logic [2:0]                funct3;
   logic [6:0]                funct7;
   logic                      accept;
   logic [INFLIGHT_CNT_W-1:0] inflight_q;
   logic                      inflight_full;

   // --------------------
   // Decode
   // --------------------
   assign opcode = issue_req_i.instr[6:0];
   assign funct3 = issue_req_i.instr[14:12];
   assign funct7 = issue_req_i.instr[31:25];

   // Only funct3 0..3 are defined, and both operands must be present
   assign accept = (opcode == OPC_CUSTOM0) &&
                   (funct7 == FUNCT7_ZERO) &&
                   !funct3[2] &&
                   (&issue_req_i.rs_valid);

   // Response is all zero on reject
   always_comb begin
      issue_resp_o           = '0;
      issue_resp_o.accept    = accept;
      issue_resp_o.writeback = accept;
   end

   assign inflight_full = (inflight_q == INFLIGHT_CNT_W'(MAX_INFLIGHT));

   // Hold off while full or while the offered id still has an entry
   assign issue_ready_o = !inflight_full && !id_busy_i[issue_req_i.id];

   // --------------------
   // Accepted transfer
   // --------------------
   assign uop_valid_o = issue_valid_i && issue_ready_o && accept;

   always_comb begin
      uop_o     = '0;
      uop_o.id  = issue_req_i.id;
      uop_o.rd  = issue_req_i.instr[11:7];
      uop_o.op  = xif_op_e'(funct3[1:0]);
      uop_o.rs0 = issue_req_i.rs[0];
      uop_o.rs1 = issue_req_i.rs[1];
   end

   // Inflight count rises on accept, falls on kill and on result read
   // (both retire bits may be set in one cycle)
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         inflight_q <= '0;
      end else begin
         inflight_q <= inflight_q
                       + INFLIGHT_CNT_W'(uop_valid_o)
                       - INFLIGHT_CNT_W'(retire_i[0])
                       - INFLIGHT_CNT_W'(retire_i[1]);
      end
   end

endmodule

`default_nettype wire

//--- design/xif_pkg.sv
/*
 * Shared constants, operation encoding and channel structs for the
 * extension-interface coprocessor. Import it wherever these types are needed.
 */

`default_nettype none

package xif_pkg;

   // --------------------
   // Sizes
   // --------------------
   localparam int XLEN         = 32;
   localparam int X_ID_WIDTH   = 3;
   localparam int X_NUM_RS     = 2;
   localparam int NUM_IDS      = 1 << X_ID_WIDTH;
   localparam int MAX_INFLIGHT = 8;

   // Wide enough to hold MAX_INFLIGHT itself
   localparam int INFLIGHT_CNT_W = $clog2(MAX_INFLIGHT + 1);

   // FIFO depths behind the commit stage
   localparam int PEND_FIFO_DEPTH = 8;
   localparam int RES_FIFO_DEPTH  = 2;

   // --------------------
   // Encodings
   // --------------------
   localparam logic [6:0] OPC_CUSTOM0  = 7'h0B;
   localparam logic [6:0] FUNCT7_ZERO  = 7'h00;
   localparam logic [5:0] EXC_OVERFLOW = 6'd2;

   // funct3 values 0..3 map straight onto the operation
   typedef enum logic [1:0] {
      OP_ADD    = 2'd0,
      OP_XOR    = 2'd1,
      OP_ROTL   = 2'd2,
      OP_ADDCHK = 2'd3
   } xif_op_e;

   // --------------------
   // Channel structs
   // --------------------
   typedef struct packed {
      logic [31:0]                          instr;
      logic [1:0]                           mode;
      logic [X_ID_WIDTH-1:0]                id;
      logic [X_NUM_RS-1:0][XLEN-1:0]        rs;
      logic [X_NUM_RS-1:0]                  rs_valid;
   } issue_req_t;

   typedef struct packed {
      logic accept;
      logic writeback;
      logic dualread;
      logic loadstore;
      logic exc;
   } issue_resp_t;

   typedef struct packed {
      logic [X_ID_WIDTH-1:0] id;
      logic                  kill;
   } commit_t;

   // Accepted instruction as it travels down the pipeline
   typedef struct packed {
      logic [X_ID_WIDTH-1:0] id;
      logic [4:0]            rd;
      xif_op_e               op;
      logic [XLEN-1:0]       rs0;
      logic [XLEN-1:0]       rs1;
   } uop_t;

   typedef struct packed {
      logic [X_ID_WIDTH-1:0] id;
      logic [4:0]            rd;
      logic [XLEN-1:0]       data;
      logic                  we;
      logic                  exc;
      logic [5:0]            exccode;
   } result_t;

endpackage

`default_nettype wire

//--- dv/tb_xif_copro.sv
/*
 * Testbench top for the coprocessor. Drives random and directed instructions,
 * commits with random kill, throttles results and prints the final verdict.
 */

`timescale 1ns/10ps
`default_nettype none

module tb_xif_copro;

   import xif_pkg::*;

   localparam int CLK_PERIOD      = 4;
   localparam int RESET_CYCLES    = 16;
   localparam int SEED            = 79;
   localparam int NUM_RANDOM      = 120;
   localparam int NUM_DIRECTED    = 13;
   localparam int NUM_TESTS       = NUM_RANDOM + NUM_DIRECTED;
   localparam int WATCHDOG_CYCLES = NUM_TESTS * 40;

   logic                  clk;
   logic                  reset_n;
   logic                  issue_valid_i;
   issue_req_t            issue_req_i;
   logic                  issue_ready_o;
   issue_resp_t           issue_resp_o;
   logic                  commit_valid_i;
   commit_t               commit_i;
   logic                  result_valid_o;
   result_t               result_o;
   logic                  result_ready_i;

   logic [X_ID_WIDTH-1:0] commit_ids [$];
   logic [X_ID_WIDTH-1:0] next_id;
   bit                    commit_en;
   int                    kill_pct;
   int                    tb_errors;
   int                    sb_errors;
   int                    sb_checked;
   int                    sb_outstanding;
   int                    total;
   issue_req_t            held_req;

   xif_copro_top dut0 (
      .clk            (clk),
      .reset_n        (reset_n),
      .issue_valid_i  (issue_valid_i),
      .issue_req_i    (issue_req_i),
      .issue_ready_o  (issue_ready_o),
      .issue_resp_o   (issue_resp_o),
      .commit_valid_i (commit_valid_i),
      .commit_i       (commit_i),
      .result_valid_o (result_valid_o),
      .result_o       (result_o),
      .result_ready_i (result_ready_i)
   );

   xif_scoreboard sb0 (
      .clk            (clk),
      .reset_n        (reset_n),
      .issue_valid_i  (issue_valid_i),
      .issue_req_i    (issue_req_i),
      .issue_ready_i  (issue_ready_o),
      .issue_resp_i   (issue_resp_o),
      .commit_valid_i (commit_valid_i),
      .commit_i       (commit_i),
      .result_valid_i (result_valid_o),
      .result_i       (result_o),
      .result_ready_i (result_ready_i),
      .err_count_o    (sb_errors),
      .checked_o      (sb_checked),
      .outstanding_o  (sb_outstanding)
   );

   bind xif_copro_top xif_protocol_sva u_sva (
      .clk            (clk),
      .reset_n        (reset_n),
      .issue_valid_i  (issue_valid_i),
      .issue_req_i    (issue_req_i),
      .issue_ready_i  (issue_ready_o),
      .issue_resp_i   (issue_resp_o),
      .result_valid_i (result_valid_o),
      .result_i       (result_o),
      .result_ready_i (result_ready_i)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // --------------------
   // Stimulus helpers
   // --------------------
   // kind 0 legal, 1 bad opcode, 2 nonzero funct7, 3 funct3 above 3, 4 missing rs
   function automatic issue_req_t make_req(input int kind, input logic [2:0] f3,
                                           input logic [X_ID_WIDTH-1:0] id,
                                           input logic [XLEN-1:0] a,
                                           input logic [XLEN-1:0] b);
      issue_req_t r;
      logic [6:0] opc;
      logic [6:0] f7;
      logic [2:0] fn;
      opc = OPC_CUSTOM0;
      f7  = 7'h00;
      fn  = f3;
      case (kind)
         1:       opc = 7'h2B;
         2:       f7 = 7'h01 | 7'($urandom % 128);
         3:       fn = f3 | 3'b100;
         default: ;
      endcase
      r.instr    = {f7, 5'($urandom), 5'($urandom), fn, 5'($urandom), opc};
      r.mode     = 2'b11;
      r.id       = id;
      r.rs[0]    = a;
      r.rs[1]    = b;
      r.rs_valid = (kind == 4) ? 2'($urandom % 3) : 2'b11;
      return r;
   endfunction

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;
      end
   endtask

   // Hold the request until ready was seen high before an edge
   task automatic wait_transfer(input bit legal);
      logic rdy;
      rdy = 1'b0;
      while (!rdy) begin
         @(negedge clk);
         rdy = issue_ready_o;
         @(posedge clk);
      end
      if (legal) begin
         commit_ids.push_back(issue_req_i.id);
      end
      #1;
      issue_valid_i = 1'b0;
   endtask

   task automatic issue_one(input int kind, input logic [2:0] f3,
                            input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
      issue_req_i   = make_req(kind, f3, next_id, a, b);
      issue_valid_i = 1'b1;
      wait_transfer(kind == 0);
      next_id++;
   endtask

   task automatic drain();
      while (commit_ids.size() != 0 || sb_outstanding != 0) begin
         @(posedge clk);
         #1;
      end
   endtask

   // One commit pulse at a time with random id order and random kill
   task automatic commit_loop();
      int idx;
      forever begin
         @(posedge clk);
         #1;
         commit_valid_i = 1'b0;
         if (commit_en && commit_ids.size() != 0 && ($urandom % 3) == 0) begin
            idx            = $urandom % commit_ids.size();
            commit_i.id    = commit_ids[idx];
            commit_i.kill  = ($urandom % 100) < kill_pct;
            commit_valid_i = 1'b1;
            commit_ids.delete(idx);
         end
      end
   endtask

   task automatic ready_loop();
      forever begin
         @(posedge clk);
         #1;
         if (($urandom % 40) == 0) begin
            // Long stall to fill the result and pending FIFOs
            result_ready_i = 1'b0;
            repeat (20 + $urandom % 20) @(posedge clk);
         end else begin
            result_ready_i = ($urandom % 4) != 0;
         end
      end
   endtask

   // --------------------
   // Main sequence
   // --------------------
   initial begin
      void'($urandom(SEED));
      clk            = 1'b0;
      reset_n        = 1'b0;
      issue_valid_i  = 1'b0;
      issue_req_i    = '0;
      commit_valid_i = 1'b0;
      commit_i       = '0;
      result_ready_i = 1'b0;
      commit_en      = 1'b1;
      kill_pct       = 25;
      tb_errors      = 0;
      next_id        = '0;
      fork
         commit_loop();
         ready_loop();
      join_none
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      reset_n = 1'b1;

      // Mixed legal and illegal traffic
      for (int i = 0; i < NUM_RANDOM; i++) begin
         issue_one((($urandom % 10) < 7) ? 0 : 1 + $urandom % 4, 3'($urandom % 4),
                   $urandom, $urandom);
         idle($urandom % 3);
      end

      // Checked add with two overflows and two plain sums
      kill_pct = 0;
      issue_one(0, 3'd3, 32'h7fff_ffff, 32'h0000_0001);
      issue_one(0, 3'd3, 32'h8000_0000, 32'hffff_ffff);
      issue_one(0, 3'd3, 32'h7fff_fffe, 32'h0000_0001);
      issue_one(0, 3'd3, 32'hffff_ffff, 32'h0000_0001);
      drain();
      kill_pct = 25;

      // Fill all ids and hold a ninth request until commits resume
      commit_en = 1'b0;
      for (int i = 0; i < MAX_INFLIGHT; i++) begin
         issue_one(0, 3'($urandom % 3), $urandom, $urandom);
      end
      held_req      = make_req(0, 3'd0, next_id, $urandom, $urandom);
      issue_req_i   = held_req;
      issue_valid_i = 1'b1;
      repeat (4) begin
         @(negedge clk);
         if (issue_ready_o) begin
            tb_errors++;
            $display("Error at %0.2f ns: issue_ready_o expected 0x0 got 0x%0h",
                     $realtime, issue_ready_o);
         end
      end
      commit_en = 1'b1;
      wait_transfer(1'b1);
      next_id++;
      drain();
      idle(20);

      total = sb_errors + tb_errors + int'(dut0.u_sva.fail_count);
      $display("Summary: %0d checked, %0d scoreboard, %0d assertion, %0d other errors",
               sb_checked, sb_errors, dut0.u_sva.fail_count, tb_errors);
      if (total == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Watchdog expired after %0d cycles and the run did not finish",
               WATCHDOG_CYCLES);
      $display("Verification failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- dv/xif_protocol_sva.sv
/*
 * Interface assertions for the coprocessor channels. Bound to the top level
 * from the testbench; failures are counted for the closing summary.
 */

`timescale 1ns/10ps
`default_nettype none

module xif_protocol_sva (
   input wire logic                 clk,
   input wire logic                 reset_n,
   input wire logic                 issue_valid_i,
   input wire xif_pkg::issue_req_t  issue_req_i,
   input wire logic                 issue_ready_i,
   input wire xif_pkg::issue_resp_t issue_resp_i,
   input wire logic                 result_valid_i,
   input wire xif_pkg::result_t     result_i,
   input wire logic                 result_ready_i
);

   int unsigned fail_count;

   initial fail_count = 0;

   // --------------------
   // Issue channel
   // --------------------
   a_issue_stable : assert property (@(posedge clk) disable iff (!reset_n)
      issue_valid_i && !issue_ready_i |=> issue_valid_i && $stable(issue_req_i))
   else begin
      fail_count++;
      $error("Issue request changed while waiting for ready");
   end

   a_reject_zero : assert property (@(posedge clk) disable iff (!reset_n)
      issue_valid_i && !issue_resp_i.accept |-> issue_resp_i == '0)
   else begin
      fail_count++;
      $error("Rejected issue has nonzero response fields");
   end

   // Single read/write port only
   a_no_dual_ls : assert property (@(posedge clk) disable iff (!reset_n)
      issue_valid_i |-> !issue_resp_i.dualread && !issue_resp_i.loadstore)
   else begin
      fail_count++;
      $error("Issue response claims dual read or load/store");
   end

   // --------------------
   // Result channel
   // --------------------
   a_result_stable : assert property (@(posedge clk) disable iff (!reset_n)
      result_valid_i && !result_ready_i |=> result_valid_i && $stable(result_i))
   else begin
      fail_count++;
      $error("Result dropped or changed while stalled");
   end

   a_exc_no_we : assert property (@(posedge clk) disable iff (!reset_n)
      result_valid_i && result_i.exc |-> !result_i.we)
   else begin
      fail_count++;
      $error("Result with exception also has write enable");
   end

endmodule

`default_nettype wire

//--- dv/xif_scoreboard.sv
/*
 * Checker for the coprocessor. Watches issue, commit and result transfers,
 * predicts each result from the instruction rules and compares in commit order.
 */

`timescale 1ns/10ps
`default_nettype none

module xif_scoreboard (
   input  wire logic                 clk,
   input  wire logic                 reset_n,
   input  wire logic                 issue_valid_i,
   input  wire xif_pkg::issue_req_t  issue_req_i,
   input  wire logic                 issue_ready_i,
   input  wire xif_pkg::issue_resp_t issue_resp_i,
   input  wire logic                 commit_valid_i,
   input  wire xif_pkg::commit_t     commit_i,
   input  wire logic                 result_valid_i,
   input  wire xif_pkg::result_t     result_i,
   input  wire logic                 result_ready_i,
   output int                        err_count_o,
   output int                        checked_o,
   output int                        outstanding_o
);

   import xif_pkg::*;

   localparam longint S32_MAX = 64'sd2147483647;
   localparam longint S32_MIN = -64'sd2147483648;

   uop_t               pend_uop [NUM_IDS];
   logic [NUM_IDS-1:0] pend_valid;
   result_t            exp_q [$];
   issue_resp_t        exp_resp;
   result_t            exp_res;
   uop_t               new_uop;
   result_t            held_res;
   logic               res_stalled;
   int                 errors;
   int                 checked;

   assign err_count_o = errors;
   assign checked_o   = checked;

   // Accept only custom-0, funct7 zero, funct3 0..3 and both operands
   function automatic issue_resp_t ref_response(input issue_req_t req);
      issue_resp_t r;
      logic        ok;
      ok = (req.instr[6:0] == OPC_CUSTOM0) && (req.instr[31:25] == 7'h00) &&
           (req.instr[14:12] < 3'd4) && (req.rs_valid == 2'b11);
      r           = '0;
      r.accept    = ok;
      r.writeback = ok;
      return r;
   endfunction

   function automatic result_t ref_result(input uop_t u);
      result_t r;
      longint  s;
      int      sh;
      r    = '0;
      r.id = u.id;
      r.rd = u.rd;
      r.we = 1'b1;
      sh   = int'(u.rs1[4:0]);
      case (u.op)
         OP_ADD:  r.data = u.rs0 + u.rs1;
         OP_XOR:  r.data = u.rs0 ^ u.rs1;
         OP_ROTL: r.data = (u.rs0 << sh) | (u.rs0 >> (XLEN - sh));
         default: begin
            s = longint'($signed(u.rs0)) + longint'($signed(u.rs1));
            if (s > S32_MAX || s < S32_MIN) begin
               r.exc     = 1'b1;
               r.exccode = 6'd2;
               r.we      = 1'b0;
            end else begin
               r.data = s[XLEN-1:0];
            end
         end
      endcase
      return r;
   endfunction

   task automatic check_field(input string name, input logic [XLEN-1:0] exp_v,
                              input logic [XLEN-1:0] got_v);
      if (exp_v !== got_v) begin
         errors++;
         $display("Error at %0.2f ns: %s expected 0x%0h got 0x%0h",
                  $realtime, name, exp_v, got_v);
      end
   endtask

   initial begin
      errors  = 0;
      checked = 0;
   end

   always @(posedge clk) begin
      if (!reset_n) begin
         pend_valid = '0;
         res_stalled = 1'b0;
         exp_q.delete();
      end else begin
         // --------------------
         // Issue response and accepted transfer
         // --------------------
         if (issue_valid_i) begin
            exp_resp = ref_response(issue_req_i);
            check_field("issue_resp_o", XLEN'(exp_resp), XLEN'(issue_resp_i));
            if (issue_ready_i && exp_resp.accept) begin
               if (pend_valid[issue_req_i.id]) begin
                  errors++;
                  $display("Id %0d accepted again while still pending", issue_req_i.id);
               end
               new_uop     = '0;
               new_uop.id  = issue_req_i.id;
               new_uop.rd  = issue_req_i.instr[11:7];
               new_uop.op  = xif_op_e'(issue_req_i.instr[13:12]);
               new_uop.rs0 = issue_req_i.rs[0];
               new_uop.rs1 = issue_req_i.rs[1];
               pend_uop[issue_req_i.id]   = new_uop;
               pend_valid[issue_req_i.id] = 1'b1;
            end
         end
         // Commit order fixes result order; killed ids are forgotten
         if (commit_valid_i && pend_valid[commit_i.id]) begin
            pend_valid[commit_i.id] = 1'b0;
            if (!commit_i.kill) begin
               exp_q.push_back(ref_result(pend_uop[commit_i.id]));
            end
         end
         // --------------------
         // Result transfer
         // --------------------
         // A stalled result comes back unchanged
         if (res_stalled) begin
            if (!result_valid_i) begin
               errors++;
               $display("Result for id %0d was withdrawn at %0.2f ns before it was taken",
                        held_res.id, $realtime);
            end else if (result_i !== held_res) begin
               errors++;
               $display("Error at %0.2f ns: result_o expected 0x%0h got 0x%0h",
                        $realtime, held_res, result_i);
            end
         end
         if (result_valid_i && result_ready_i) begin
            if (exp_q.size() == 0) begin
               errors++;
               $display("Unexpected result for id %0d at %0.2f ns, nothing was due",
                        result_i.id, $realtime);
            end else begin
               exp_res = exp_q.pop_front();
               check_field("result_o.id", XLEN'(exp_res.id), XLEN'(result_i.id));
               check_field("result_o.rd", XLEN'(exp_res.rd), XLEN'(result_i.rd));
               check_field("result_o.we", XLEN'(exp_res.we), XLEN'(result_i.we));
               check_field("result_o.exc", XLEN'(exp_res.exc), XLEN'(result_i.exc));
               check_field("result_o.exccode", XLEN'(exp_res.exccode),
                           XLEN'(result_i.exccode));
               if (!exp_res.exc) begin
                  check_field("result_o.data", exp_res.data, result_i.data);
               end
               checked++;
            end
         end
         res_stalled = result_valid_i && !result_ready_i;
         held_res    = result_i;
      end
      outstanding_o = exp_q.size() + $countones(pend_valid);
   end

endmodule

`default_nettype wire
